// ==== Bender.yml ====
package:
  name: quant

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/quant_pkg.sv
      - rtl/quant_tables.sv
      - rtl/quant_mcu_tracker.sv
      - rtl/quant_mult.sv
      - rtl/quant_delay.sv
      - rtl/quant.sv
      - target: test
        files:
          - verification/quant_tb.sv

// ==== all.f ====
+incdir+rtl
rtl/quant_pkg.sv
rtl/quant_tables.sv
rtl/quant_mcu_tracker.sv
rtl/quant_mult.sv
rtl/quant_delay.sv
rtl/quant.sv
verification/quant_tb.sv

// ==== rtl/quant.sv ====
// Two zigzag coefficients per beat, 32 beats per block; tables must be loaded before streaming
`timescale 1ns/1ps
`default_nettype none

module quant
    import quant_pkg::*;
#(
    parameter int DW = 15,
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic signed [DW-1:0]             di [2],
    input  logic                             di_valid,
    input  logic [4:0]                       di_cnt,
    output logic                             di_hold,
    output logic signed [DW-5:0]             q [2],
    output logic                             q_valid,
    input  logic                             q_hold,
    output quant_side_t                      q_side,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1,
    input  wb_req_t                          wb_req,
    output wb_rsp_t                          wb_rsp
);

    `include "zigzag.svh"

    // DCT growth leaves four bits of headroom after quantization
    localparam int QW = DW - 4;
    localparam int PW = DW + QF_BITS + 1;

    if (DW < 12 || DW > 16) begin : g_dw_check
        $error("quant: DW must be between 12 and 16");
    end

    logic                      accept;
    logic                      en;
    chroma_t                   chroma;
    logic                      chroma_table;
    logic                      last_mcu;
    logic [TABLE_ADR_BITS-1:0] q_ra [2];
    logic [QF_BITS-1:0]        q_factor [2];

    // Input stage, loaded on each accepted beat
    logic signed [DW-1:0]      di0 [2];
    logic [QF_BITS-1:0]        qf0 [2];
    logic                      di0_valid;
    quant_side_t               side0;

    logic signed [PW-1:0]      mult_out [2];
    logic [1:0]                lane_valid;

    always_comb begin
        accept = di_valid && !q_hold;
        en = !q_hold;
        di_hold = q_hold;
    end

    quant_mcu_tracker #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE)
    ) tracker_inst (
        .clk          (clk),
        .resetn       (resetn),
        .accept       (accept),
        .cnt          (di_cnt),
        .x_size_m1    (x_size_m1),
        .y_size_m1    (y_size_m1),
        .chroma       (chroma),
        .chroma_table (chroma_table),
        .last_mcu     (last_mcu)
    );

    // Lane i reads natural position of zigzag index 2*cnt+i
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            q_ra[i] = {chroma_table, de_zigzag({di_cnt, 1'(i)})};
        end
    end

    quant_tables #(
        .N_READ (2)
    ) tables_inst (
        .clk    (clk),
        .resetn (resetn),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .ra     (q_ra),
        .rd     (q_factor)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            di0_valid <= 1'b0;
        end else if (en) begin
            di0_valid <= di_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            di0 <= di;
            qf0 <= q_factor;
            side0 <= '{last_mcu: last_mcu, chroma: chroma, cnt: di_cnt};
        end
    end

    for (genvar i = 0; i < 2; i++) begin : g_lane
        quant_mult #(
            .AW (DW),
            .BW (QF_BITS)
        ) mult_inst (
            .clk       (clk),
            .resetn    (resetn),
            .en        (en),
            .in_valid  (di0_valid && en),
            .a_in      (di0[i]),
            .b_in      (qf0[i]),
            .out       (mult_out[i]),
            .out_valid (lane_valid[i])
        );

        // Scale back by the reciprocal's fixed point and keep QW bits
        always_comb begin
            q[i] = QW'(mult_out[i] >>> QF_SHIFT);
        end
    end

    quant_delay #(
        .T (quant_side_t)
    ) side_delay_inst (
        .clk  (clk),
        .en   (en),
        .din  (side0),
        .dout (q_side)
    );

    always_comb begin
        q_valid = &lane_valid;
    end

    // Hold must freeze the whole pipeline, sideband included
    a_hold_freeze: assert property (
        @(posedge clk) disable iff (!resetn)
        q_hold && q_valid |=> $stable(q_valid) && $stable(q_side)
    ) else $error("output moved while q_hold was high");

endmodule

`default_nettype wire

// ==== rtl/quant_delay.sv ====
// Enabled shift register matching the multiplier latency; payload has no reset
`timescale 1ns/1ps
`default_nettype none

module quant_delay
    import quant_pkg::*;
#(
    parameter type T = logic
) (
    input  logic clk,
    input  logic en,
    input  T     din,
    output T     dout
);

    T stage [MULT_STAGES];

    always_ff @(posedge clk) begin
        if (en) begin
            stage[0] <= din;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    always_comb begin
        dout = stage[MULT_STAGES-1];
    end

endmodule

`default_nettype wire

// ==== rtl/quant_mcu_tracker.sv ====
// Assumes sensor sizes above 16 pixels and a frame of whole 16x16 MCUs; block order Y Y Y Y U V
`timescale 1ns/1ps
`default_nettype none

module quant_mcu_tracker
    import quant_pkg::*;
#(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             accept,
    input  logic [4:0]                       cnt,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1,
    output chroma_t                          chroma,
    output logic                             chroma_table,
    output logic                             last_mcu
);

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);

    logic [2:0]    blk;
    logic [XW-5:0] x_mcu;
    logic [YW-5:0] y_mcu;
    logic [XW-5:0] x_last;
    logic [YW-5:0] y_last;
    logic          block_end;
    logic          mcu_end;

    always_comb begin
        // Last MCU column and row, from the run-time frame size
        x_last = x_size_m1[XW-1:4];
        y_last = y_size_m1[YW-1:4];
        block_end = accept && (cnt == 5'(BEATS_PER_BLOCK - 1));
        mcu_end = block_end && (blk == 3'(BLOCKS_PER_MCU - 1));
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            blk <= '0;
            x_mcu <= '0;
            y_mcu <= '0;
        end else begin
            if (block_end) begin
                blk <= mcu_end ? 3'd0 : blk + 3'd1;
            end
            if (mcu_end) begin
                if (x_mcu == x_last) begin
                    x_mcu <= '0;
                    y_mcu <= (y_mcu == y_last) ? '0 : y_mcu + 1'b1;
                end else begin
                    x_mcu <= x_mcu + 1'b1;
                end
            end
        end
    end

    // State of the block that is entering now
    always_comb begin
        case (blk)
            3'd4:    chroma = CHROMA_U;
            3'd5:    chroma = CHROMA_V;
            default: chroma = CHROMA_Y;
        endcase
        chroma_table = blk[2];
        last_mcu = (blk == 3'(BLOCKS_PER_MCU - 1)) && (x_mcu == x_last) && (y_mcu == y_last);
    end

    a_blk_range: assert property (
        @(posedge clk) disable iff (!resetn)
        blk < 3'(BLOCKS_PER_MCU)
    ) else $error("block counter left the MCU");

endmodule

`default_nettype wire

// ==== rtl/quant_mult.sv ====
// Signed coefficient times unsigned factor; full-width product, latency fixed by the package
`timescale 1ns/1ps
`default_nettype none

module quant_mult
    import quant_pkg::*;
#(
    parameter int AW = 15,
    parameter int BW = 13
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    en,
    input  logic                    in_valid,
    input  logic signed [AW-1:0]    a_in,
    input  logic        [BW-1:0]    b_in,
    output logic signed [AW+BW:0]   out,
    output logic                    out_valid
);

    // Operand register, then MULT_STAGES-1 product stages for retiming
    logic signed [AW-1:0]  a_r;
    logic        [BW-1:0]  b_r;
    logic signed [AW+BW:0] prod [MULT_STAGES-1];
    logic [MULT_STAGES-1:0] vld;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld <= '0;
        end else if (en) begin
            vld <= {vld[MULT_STAGES-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            a_r <= a_in;
            b_r <= b_in;
            // Zero-extend the factor so the product stays signed
            prod[0] <= a_r * $signed({1'b0, b_r});
            for (int s = 1; s < MULT_STAGES - 1; s++) begin
                prod[s] <= prod[s-1];
            end
        end
    end

    always_comb begin
        out = prod[MULT_STAGES-2];
        out_valid = vld[MULT_STAGES-1];
    end

endmodule

`default_nettype wire

// ==== rtl/quant_pkg.sv ====
// Quantizer constants and bus structs; the factor width and the shift are fixed here, not per instance
`default_nettype none

package quant_pkg;

    // Reciprocal quantization factor, as stored in the tables
    localparam int QF_BITS = 13;
    localparam int QF_SHIFT = 12;

    // Latency of the multiplier and of the sideband delay line
    localparam int MULT_STAGES = 4;

    // 4:2:0 MCU is four Y blocks, then U, then V
    localparam int BLOCKS_PER_MCU = 6;
    localparam int BEATS_PER_BLOCK = 32;

    // Bit 6 picks the chroma table, bits 5..0 hold the natural position
    localparam int TABLE_ADR_BITS = 7;

    typedef enum logic [1:0] {
        CHROMA_Y = 2'd0,
        CHROMA_U = 2'd1,
        CHROMA_V = 2'd2
    } chroma_t;

    // Sideband that travels with each coefficient beat
    typedef struct packed {
        logic       last_mcu;
        chroma_t    chroma;
        logic [4:0] cnt;
    } quant_side_t;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [TABLE_ADR_BITS-1:0] adr;
        logic [QF_BITS-1:0]        dat;
    } wb_req_t;

    typedef struct packed {
        logic               ack;
        logic [QF_BITS-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/quant_tables.sv ====
// Factor RAM has no reset and no defaults; entries read back undefined until written over Wishbone
`timescale 1ns/1ps
`default_nettype none

module quant_tables
    import quant_pkg::*;
#(
    parameter int N_READ = 2
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  wb_req_t                   wb_req,
    output wb_rsp_t                   wb_rsp,
    input  logic [TABLE_ADR_BITS-1:0] ra [N_READ],
    output logic [QF_BITS-1:0]        rd [N_READ]
);

    localparam int DEPTH = 2 ** TABLE_ADR_BITS;

    // Luma in the lower half, chroma in the upper half
    logic [QF_BITS-1:0] mem [DEPTH];

    logic               ack_q;
    logic [QF_BITS-1:0] dat_q;
    logic               req_go;
    logic               wr_en;

    // A new request is one that has not been acknowledged yet
    always_comb begin
        req_go = wb_req.cyc && wb_req.stb && !ack_q;
        wr_en = req_go && wb_req.we;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_go;
        end
    end

    // Entry is written on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wb_req.adr] <= wb_req.dat;
        end
    end

    // Read-back data, held for the ack cycle
    always_ff @(posedge clk) begin
        if (req_go) begin
            dat_q <= mem[wb_req.adr];
        end
    end

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = dat_q;
    end

    // Datapath ports, combinational
    always_comb begin
        for (int i = 0; i < N_READ; i++) begin
            rd[i] = mem[ra[i]];
        end
    end

    // Classic handshake gives one ack per strobe, even if the master is slow to drop stb
    a_single_ack: assert property (
        @(posedge clk) disable iff (!resetn)
        wb_rsp.ack && wb_req.cyc && wb_req.stb |=> !wb_rsp.ack
    ) else $error("ack held high for two cycles under one strobe");

endmodule

`default_nettype wire

// ==== rtl/zigzag.svh ====
// Include inside a module body; maps zigzag order to natural order for one 8x8 block only

// Zigzag index in, row-major natural index out
function automatic logic [5:0] de_zigzag(input logic [5:0] zz);
    // Element 0 comes first in the list
    localparam logic [0:63][5:0] NATURAL = {
        6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
        6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
        6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
        6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
        6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
        6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
        6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
        6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
    };
    return NATURAL[zz];
endfunction

// ==== verification/quant_tb.sv ====
// Default DUT parameters only; tables are loaded over Wishbone first, and stream tests run in order
`timescale 1ns/1ps
`default_nettype none

module quant_tb
    import quant_pkg::*;
;

    `include "zigzag.svh"

    localparam int DW = 15;
    localparam int QW = DW - 4;
    localparam int XW = $clog2(720);
    localparam int YW = $clog2(720);
    localparam int N_STIM = 4;

    // Stream test with MCU count, hold bursts, frame size and the first pair of each block
    typedef struct packed {
        logic [3:0]           n_mcus;
        logic                 use_hold;
        logic                 big_frame;
        logic signed [DW-1:0] c0;
        logic signed [DW-1:0] c1;
        logic [9:0]           exp_last;
    } stim_t;

    typedef struct packed {
        quant_side_t          side;
        logic signed [QW-1:0] q0;
        logic signed [QW-1:0] q1;
    } exp_beat_t;

    logic                 clk;
    logic                 resetn;
    logic signed [DW-1:0] di [2];
    logic                 di_valid;
    logic [4:0]           di_cnt;
    logic                 di_hold;
    logic signed [QW-1:0] q [2];
    logic                 q_valid;
    logic                 q_hold;
    quant_side_t          q_side;
    logic [XW-1:0]        x_size_m1;
    logic [YW-1:0]        y_size_m1;
    wb_req_t              wb_req;
    wb_rsp_t              wb_rsp;

    integer               seed;
    int                   errors;
    int                   n_pass;
    int                   n_fail;
    logic [QF_BITS-1:0]   model_tab [2 ** TABLE_ADR_BITS];
    exp_beat_t            exp_q [$];
    stim_t                stim [N_STIM];
    string                stim_name [N_STIM];

    // Model of the block and MCU position
    int                   m_blk;
    int                   m_x;
    int                   m_y;

    quant quant_inst (
        .clk       (clk),
        .resetn    (resetn),
        .di        (di),
        .di_valid  (di_valid),
        .di_cnt    (di_cnt),
        .di_hold   (di_hold),
        .q         (q),
        .q_valid   (q_valid),
        .q_hold    (q_hold),
        .q_side    (q_side),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_coef(input string name, input logic signed [QW-1:0] got,
                              input logic signed [QW-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_side(input string name, input quant_side_t got, input quant_side_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_wb(input string name, input wb_rsp_t got, input logic [QF_BITS-1:0] exp);
        if (got.dat !== exp) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, got.dat, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    // Reciprocal multiply, shift by 12, keep the low QW bits
    function automatic logic signed [QW-1:0] quantize(input logic signed [DW-1:0] c,
                                                      input logic [QF_BITS-1:0] f);
        longint p;
        p = longint'(c) * longint'(f);
        return QW'(p >>> QF_SHIFT);
    endfunction

    task automatic wb_cycle(input logic we, input logic [TABLE_ADR_BITS-1:0] adr,
                            input logic [QF_BITS-1:0] dat, output wb_rsp_t rsp);
        int guard;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        guard = 0;
        rsp = '0;
        do begin
            @(negedge clk);
            guard++;
        end while (!wb_rsp.ack && guard < 20);
        if (wb_rsp.ack) begin
            rsp = wb_rsp;
        end else begin
            $display("Wishbone ack did not arrive for address 0x%h", adr);
            errors++;
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic run_stream(input string name, input stim_t st);
        int                   total;
        int                   sent;
        int                   n_in;
        int                   n_out;
        int                   n_last;
        int                   guard;
        int                   tail;
        logic [4:0]           cnt;
        logic                 tsel;
        logic signed [DW-1:0] cur [2];
        logic                 prev_hold;
        logic                 prev_valid;
        logic signed [QW-1:0] prev_q [2];
        quant_side_t          prev_side;
        exp_beat_t            e;
        total = st.n_mcus * BLOCKS_PER_MCU * BEATS_PER_BLOCK;
        sent = 0;
        n_in = 0;
        n_out = 0;
        n_last = 0;
        guard = 0;
        tail = 0;
        prev_hold = 1'b0;
        cur[0] = st.c0;
        cur[1] = st.c1;
        @(posedge clk);
        x_size_m1 <= st.big_frame ? XW'(31) : XW'(15);
        y_size_m1 <= st.big_frame ? YW'(31) : YW'(15);
        while ((sent < total || exp_q.size() != 0 || tail < 8) && guard < total * 4 + 200) begin
            @(posedge clk);
            q_hold <= st.use_hold ? (($random(seed) & 3) == 0) : 1'b0;
            if (sent < total) begin
                di_valid <= st.use_hold ? (($random(seed) & 7) != 0) : 1'b1;
                di[0] <= cur[0];
                di[1] <= cur[1];
                di_cnt <= 5'(sent % BEATS_PER_BLOCK);
            end else begin
                di_valid <= 1'b0;
            end
            @(negedge clk);
            if (di_hold !== q_hold) begin
                $display("FAILED di_hold: got 0x%h expected 0x%h", di_hold, q_hold);
                errors++;
            end
            // Outputs must not move across a cycle with q_hold high
            if (prev_hold) begin
                if (q_valid !== prev_valid) begin
                    $display("FAILED q_valid: got 0x%h expected 0x%h", q_valid, prev_valid);
                    errors++;
                end
                check_coef("q[0] under hold", q[0], prev_q[0]);
                check_coef("q[1] under hold", q[1], prev_q[1]);
                check_side("q_side under hold", q_side, prev_side);
            end
            if (di_valid && !q_hold) begin
                cnt = di_cnt;
                tsel = (m_blk >= 4);
                e.side.cnt = cnt;
                e.side.chroma = (m_blk == 4) ? CHROMA_U : (m_blk == 5) ? CHROMA_V : CHROMA_Y;
                e.side.last_mcu = (m_blk == 5) && (m_x == (x_size_m1 >> 4))
                                  && (m_y == (y_size_m1 >> 4));
                e.q0 = quantize(di[0], model_tab[{tsel, de_zigzag({cnt, 1'b0})}]);
                e.q1 = quantize(di[1], model_tab[{tsel, de_zigzag({cnt, 1'b1})}]);
                exp_q.push_back(e);
                if (cnt == 5'd31) begin
                    if (m_blk == 5) begin
                        m_blk = 0;
                        if (m_x == (x_size_m1 >> 4)) begin
                            m_x = 0;
                            m_y = (m_y == (y_size_m1 >> 4)) ? 0 : m_y + 1;
                        end else begin
                            m_x++;
                        end
                    end else begin
                        m_blk++;
                    end
                end
                sent++;
                n_in++;
                cur[0] = DW'($random(seed));
                cur[1] = DW'($random(seed));
                if (sent % BEATS_PER_BLOCK == 0) begin
                    cur[0] = st.c0;
                    cur[1] = st.c1;
                end
            end
            if (q_valid && !q_hold) begin
                n_out++;
                if (exp_q.size() == 0) begin
                    $display("output beat arrived with no input beat pending");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_coef("q[0]", q[0], e.q0);
                    check_coef("q[1]", q[1], e.q1);
                    check_side("q_side", q_side, e.side);
                    if (q_side.last_mcu) begin
                        n_last++;
                    end
                end
            end
            prev_hold = q_hold;
            prev_valid = q_valid;
            prev_q = q;
            prev_side = q_side;
            if (sent == total && exp_q.size() == 0) begin
                tail++;
            end
            guard++;
        end
        @(posedge clk);
        di_valid <= 1'b0;
        q_hold <= 1'b0;
        if (guard >= total * 4 + 200) begin
            $display("timeout waiting for output beats, %0d still pending", exp_q.size());
            errors++;
        end
        if (n_out != n_in) begin
            $display("%0d beats went in but %0d came out", n_in, n_out);
            errors++;
        end
        if (n_last != st.exp_last) begin
            $display("last_mcu was high on %0d beats instead of %0d", n_last, st.exp_last);
            errors++;
        end
        exp_q.delete();
    endtask

    initial begin
        int      start;
        wb_rsp_t rsp;
        seed = 24;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        m_blk = 0;
        m_x = 0;
        m_y = 0;
        resetn <= 1'b0;
        di[0] <= '0;
        di[1] <= '0;
        di_valid <= 1'b0;
        di_cnt <= '0;
        q_hold <= 1'b0;
        x_size_m1 <= XW'(15);
        y_size_m1 <= YW'(15);
        wb_req <= '0;

        // Fields in order are MCUs, hold, 32x32 frame, first pair and beats with last_mcu
        stim[0] = '{n_mcus: 1, use_hold: 0, big_frame: 0, c0: DW'(16383), c1: DW'(-16384),
                    exp_last: 32};
        stim[1] = '{n_mcus: 2, use_hold: 0, big_frame: 0, c0: DW'(0), c1: DW'(-1),
                    exp_last: 64};
        stim[2] = '{n_mcus: 8, use_hold: 0, big_frame: 1, c0: DW'(4096), c1: DW'(-4097),
                    exp_last: 64};
        stim[3] = '{n_mcus: 2, use_hold: 1, big_frame: 0, c0: DW'(1), c1: DW'(-100),
                    exp_last: 64};
        stim_name[0] = "quantization";
        stim_name[1] = "component sequencing";
        stim_name[2] = "last MCU flag";
        stim_name[3] = "back-pressure";

        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        start = errors;
        if (q_valid !== 1'b0) begin
            $display("FAILED q_valid: got 0x%h expected 0x0", q_valid);
            errors++;
        end
        if (wb_rsp.ack !== 1'b0) begin
            $display("FAILED wb_rsp.ack: got 0x%h expected 0x0", wb_rsp.ack);
            errors++;
        end
        finish_test("reset state", start);

        start = errors;
        for (int a = 0; a < 2 ** TABLE_ADR_BITS; a++) begin
            model_tab[a] = QF_BITS'($random(seed));
            wb_cycle(1'b1, TABLE_ADR_BITS'(a), model_tab[a], rsp);
        end
        for (int a = 0; a < 2 ** TABLE_ADR_BITS; a++) begin
            wb_cycle(1'b0, TABLE_ADR_BITS'(a), '0, rsp);
            if (rsp.ack) begin
                check_wb("wb_rsp.dat", rsp, model_tab[a]);
            end
        end
        finish_test("table load and read-back", start);

        for (int i = 0; i < N_STIM; i++) begin
            start = errors;
            run_stream(stim_name[i], stim[i]);
            finish_test(stim_name[i], start);
        end

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
